/* Makefile */
SIM := obj_dir/Vts_monitor_tb
SOURCES := $(filter-out +%,$(shell cat tb.f)) hw/ts_monitor_settings.svh

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): tb.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module ts_monitor_tb -f tb.f

clean:
	rm -rf obj_dir

/* hw/packet_capture.sv */
`timescale 1ns/1ps
`include "ts_monitor_settings.svh"

module packet_capture (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        pkt_start,
	input  logic                        pkt_drop,
	input  ts_monitor_pkg::ts_byte_t    tail_byte,
	input  logic                        tail_valid,
	input  logic                        capture_bank,
	input  logic                        rd_bank,
	input  ts_monitor_pkg::word_index_t rd_addr,
	output ts_monitor_pkg::bus_word_t   rd_word,
	output logic                        busy
);

	// two banks of byte-lane words, lane 0 holds the lowest byte.
	logic [`TS_WORD_BYTES-1:0][7:0] bank_mem [0:1][0:`TS_PACKET_WORDS-1];

	ts_monitor_pkg::byte_index_t byte_count;
	ts_monitor_pkg::word_index_t wr_word;
	logic [1:0] wr_lane;
	logic wr_en;
	logic last_byte;

	assign wr_en = busy && tail_valid && (byte_count < `TS_PACKET_BYTES);
	assign wr_word = ts_monitor_pkg::word_index_t'(byte_count / `TS_WORD_BYTES);
	assign wr_lane = 2'(byte_count % `TS_WORD_BYTES);
	assign last_byte = (byte_count == 8'(`TS_PACKET_BYTES - 1));

	always_ff @(posedge clk) begin
		if (wr_en) begin
			bank_mem[capture_bank][wr_word][wr_lane] <= tail_byte;
		end
	end

	// a new header may coincide with the final byte of the previous packet,
	// so the write above still happens while the counter restarts here.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			byte_count <= '0;
			busy <= 1'b0;
		end else begin
			if (wr_en) begin
				byte_count <= byte_count + 1'b1;
				if (last_byte) begin
					busy <= 1'b0;
				end
			end
			if (pkt_start) begin
				byte_count <= '0;
				busy <= 1'b1;
			end else if (pkt_drop) begin
				busy <= 1'b0;
			end
		end
	end

	assign rd_word = bank_mem[rd_bank][rd_addr];

endmodule

/* hw/packet_pump.sv */
`timescale 1ns/1ps
`include "ts_monitor_settings.svh"

module packet_pump (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        pump_request,
	input  logic                        busy,
	output logic                        capture_bank,
	output logic                        rd_bank,
	output ts_monitor_pkg::word_index_t rd_addr,
	input  ts_monitor_pkg::bus_word_t   rd_word,
	output logic                        pump_ready,
	output ts_monitor_pkg::bus_word_t   out_word,
	output ts_monitor_pkg::word_index_t out_word_index,
	output logic                        out_word_valid
);

	typedef enum logic {
		st_idle,
		st_readout
	} pump_state_t;

	pump_state_t state;
	logic last_out;

	localparam ts_monitor_pkg::word_index_t last_word = 6'(`TS_PACKET_WORDS - 1);

	// the readout is over once the final word has been presented.
	assign last_out = out_word_valid && (out_word_index == last_word);
	assign rd_bank = !capture_bank;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			capture_bank <= 1'b0;
			rd_addr <= '0;
			pump_ready <= 1'b0;
			out_word_valid <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (pump_request) begin
						// a half-written packet keeps its bank.
						if (!busy) begin
							capture_bank <= !capture_bank;
						end
						rd_addr <= '0;
						pump_ready <= 1'b0;
						state <= st_readout;
					end
				end
				st_readout: begin
					if (last_out) begin
						out_word_valid <= 1'b0;
						pump_ready <= 1'b1;
						state <= st_idle;
					end else begin
						out_word_valid <= 1'b1;
						if (rd_addr != last_word) begin
							rd_addr <= rd_addr + 1'b1;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == st_readout) && !last_out) begin
			out_word <= rd_word;
			out_word_index <= rd_addr;
		end
	end

endmodule

/* hw/pid_match_ctrl.sv */
`timescale 1ns/1ps
`include "ts_monitor_settings.svh"

module pid_match_ctrl (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      cfg_write,
	input  ts_monitor_pkg::bus_word_t cfg_index,
	input  ts_monitor_pkg::bus_word_t cfg_data,
	output ts_monitor_pkg::bus_word_t cfg_readback,
	input  logic                      match_enable,
	input  logic                      hdr_found,
	input  ts_monitor_pkg::pid_t      hdr_pid,
	output logic                      pkt_start,
	output logic                      pkt_drop
);

	ts_monitor_pkg::pid_t cfg_pid;
	logic cfg_enable;
	logic pid_hit;

	// only slot 0 exists; other indices are silently ignored.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg_pid <= '0;
			cfg_enable <= 1'b0;
		end else if (cfg_write && (cfg_index == '0)) begin
			cfg_pid <= cfg_data[12:0];
			cfg_enable <= cfg_data[`TS_CFG_ENABLE_BIT];
		end
	end

	always_comb begin
		cfg_readback = '0;
		cfg_readback[12:0] = cfg_pid;
		cfg_readback[`TS_CFG_ENABLE_BIT] = cfg_enable;
	end

	assign pid_hit = (hdr_pid == cfg_pid) && cfg_enable && match_enable;

	// every header produces exactly one of the two decisions.
	assign pkt_start = hdr_found && pid_hit;
	assign pkt_drop = hdr_found && !pid_hit;

endmodule

/* hw/ts_header_detect.sv */
`timescale 1ns/1ps
`include "ts_monitor_settings.svh"

module ts_header_detect (
	input  logic                   clk,
	input  logic                   rst_n,
	input  ts_monitor_pkg::ts_byte_t ts_data,
	input  logic                   ts_sync,
	input  logic                   ts_valid,
	output logic                   hdr_found,
	output ts_monitor_pkg::pid_t   hdr_pid,
	output ts_monitor_pkg::ts_byte_t tail_byte,
	output logic                   tail_valid
);

	ts_monitor_pkg::ts_byte_t data_d1;
	ts_monitor_pkg::ts_byte_t data_d2;
	ts_monitor_pkg::ts_byte_t data_d3;
	logic sync_d1;
	logic sync_d2;

	// byte delay line, advanced once per strobe.
	always_ff @(posedge clk) begin
		if (ts_valid) begin
			data_d1 <= ts_data;
			data_d2 <= data_d1;
			data_d3 <= data_d2;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_d1 <= 1'b0;
			sync_d2 <= 1'b0;
		end else if (ts_valid) begin
			sync_d1 <= ts_sync;
			sync_d2 <= sync_d1;
		end
	end

	// when the sync byte sits two places back, the PID bytes are d1 and the input.
	assign hdr_found = ts_valid && sync_d2 && (data_d2 == `TS_SYNC_BYTE);
	assign hdr_pid = {data_d1[4:0], ts_data};

	// the oldest stage leaves the line on the same strobe that shifts it.
	assign tail_byte = data_d3;
	assign tail_valid = ts_valid;

endmodule

/* hw/ts_monitor_pkg.sv */
package ts_monitor_pkg;

	// one byte of the incoming stream.
	typedef logic [7:0] ts_byte_t;

	// 13-bit packet identifier from the header.
	typedef logic [12:0] pid_t;

	// config and readout data word.
	typedef logic [31:0] bus_word_t;

	// word address inside one bank, 0 to 46.
	typedef logic [5:0] word_index_t;

	// byte position inside a packet, 0 to 188.
	typedef logic [7:0] byte_index_t;

endpackage

/* hw/ts_monitor_settings.svh */
`ifndef TS_MONITOR_SETTINGS_SVH
`define TS_MONITOR_SETTINGS_SVH

// one transport stream packet, header included.
`define TS_PACKET_BYTES 188
`define TS_SYNC_BYTE 8'h47

// the bus word carries four stream bytes, lowest byte first.
`define TS_WORD_BYTES 4
`define TS_PACKET_WORDS 47

// config word layout: PID in bits 12:0, enable flag here.
`define TS_CFG_ENABLE_BIT 16

`endif

/* hw/ts_monitor_top.sv */
`timescale 1ns/1ps

module ts_monitor_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  ts_monitor_pkg::ts_byte_t    ts_data,
	input  logic                        ts_sync,
	input  logic                        ts_valid,
	input  logic                        match_enable,
	input  logic                        cfg_write,
	input  ts_monitor_pkg::bus_word_t   cfg_index,
	input  ts_monitor_pkg::bus_word_t   cfg_data,
	output ts_monitor_pkg::bus_word_t   cfg_readback,
	input  logic                        pump_request,
	output logic                        pump_ready,
	output ts_monitor_pkg::bus_word_t   out_word,
	output ts_monitor_pkg::word_index_t out_word_index,
	output logic                        out_word_valid
);

	logic hdr_found;
	ts_monitor_pkg::pid_t hdr_pid;
	ts_monitor_pkg::ts_byte_t tail_byte;
	logic tail_valid;
	logic pkt_start;
	logic pkt_drop;
	logic busy;
	logic capture_bank;
	logic rd_bank;
	ts_monitor_pkg::word_index_t rd_addr;
	ts_monitor_pkg::bus_word_t rd_word;

	ts_header_detect u_header_detect (
		.clk(clk), .rst_n(rst_n), .ts_data(ts_data), .ts_sync(ts_sync),
		.ts_valid(ts_valid), .hdr_found(hdr_found), .hdr_pid(hdr_pid),
		.tail_byte(tail_byte), .tail_valid(tail_valid)
	);

	pid_match_ctrl u_pid_match_ctrl (
		.clk(clk), .rst_n(rst_n), .cfg_write(cfg_write), .cfg_index(cfg_index),
		.cfg_data(cfg_data), .cfg_readback(cfg_readback), .match_enable(match_enable),
		.hdr_found(hdr_found), .hdr_pid(hdr_pid), .pkt_start(pkt_start),
		.pkt_drop(pkt_drop)
	);

	packet_capture u_packet_capture (
		.clk(clk), .rst_n(rst_n), .pkt_start(pkt_start), .pkt_drop(pkt_drop),
		.tail_byte(tail_byte), .tail_valid(tail_valid), .capture_bank(capture_bank),
		.rd_bank(rd_bank), .rd_addr(rd_addr), .rd_word(rd_word), .busy(busy)
	);

	packet_pump u_packet_pump (
		.clk(clk), .rst_n(rst_n), .pump_request(pump_request), .busy(busy),
		.capture_bank(capture_bank), .rd_bank(rd_bank), .rd_addr(rd_addr),
		.rd_word(rd_word), .pump_ready(pump_ready), .out_word(out_word),
		.out_word_index(out_word_index), .out_word_valid(out_word_valid)
	);

endmodule

/* tb.f */
+incdir+hw
hw/ts_monitor_pkg.sv
hw/ts_header_detect.sv
hw/pid_match_ctrl.sv
hw/packet_capture.sv
hw/packet_pump.sv
hw/ts_monitor_top.sv
tb/ts_monitor_sva.sv
tb/ts_monitor_tb.sv

/* tb/ts_monitor_sva.sv */
`timescale 1ns/1ps

module ts_monitor_sva (
	input logic                        clk,
	input logic                        rst_n,
	input logic                        busy,
	input logic                        capture_bank,
	input logic                        pump_ready,
	input logic                        out_word_valid,
	input ts_monitor_pkg::word_index_t out_word_index
);

	// words are only presented during a readout, never while the pump is ready.
	valid_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
		!(out_word_valid && pump_ready))
	else $error("out_word_valid is high while pump_ready is high");

	// consecutive words of one readout carry consecutive indices.
	index_steps_by_one: assert property (@(posedge clk) disable iff (!rst_n)
		(out_word_valid && $past(out_word_valid))
		|-> (out_word_index == $past(out_word_index) + 6'd1))
	else $error("out_word_index did not advance by one within a readout");

	// a partly written packet keeps its bank.
	bank_held_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		busy |=> $stable(capture_bank))
	else $error("capture_bank changed while busy was high");

endmodule

bind packet_pump ts_monitor_sva pump_checks (
	.clk(clk), .rst_n(rst_n), .busy(busy), .capture_bank(capture_bank),
	.pump_ready(pump_ready), .out_word_valid(out_word_valid),
	.out_word_index(out_word_index)
);

/* tb/ts_monitor_tb.sv */
`timescale 1ns/1ps
`include "ts_monitor_settings.svh"

module ts_monitor_tb;

	logic clk = 1'b0;
	logic rst_n;
	ts_monitor_pkg::ts_byte_t ts_data;
	logic ts_sync;
	logic ts_valid;
	logic match_enable;
	logic cfg_write;
	ts_monitor_pkg::bus_word_t cfg_index;
	ts_monitor_pkg::bus_word_t cfg_data;
	ts_monitor_pkg::bus_word_t cfg_readback;
	logic pump_request;
	logic pump_ready;
	ts_monitor_pkg::bus_word_t out_word;
	ts_monitor_pkg::word_index_t out_word_index;
	logic out_word_valid;

	integer seed = 32'h038b_1922;
	ts_monitor_pkg::ts_byte_t pkt [0:`TS_PACKET_BYTES-1];
	// reference copy of both banks, with a flag for banks that hold a whole packet.
	ts_monitor_pkg::bus_word_t model_bank [0:1][0:`TS_PACKET_WORDS-1];
	logic model_known [0:1];
	logic model_cap;
	logic model_busy;
	logic model_enable;
	logic model_flag;
	ts_monitor_pkg::pid_t model_pid;

	ts_monitor_top UUT (.*);

	always #50 clk = ~clk;

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else fail_now($sformatf("mismatch at %0t: %s is %h, expected %h",
			$time, name, got, exp));
	endtask

	task automatic build_packet(input ts_monitor_pkg::ts_byte_t first,
		input ts_monitor_pkg::pid_t pid);
		pkt[0] = first;
		pkt[1] = {3'($random(seed)), pid[12:8]};
		pkt[2] = pid[7:0];
		for (int n = 3; n < `TS_PACKET_BYTES; n++) begin
			pkt[n] = 8'($random(seed));
		end
	endtask

	task automatic send_byte(input ts_monitor_pkg::ts_byte_t value, input logic sync,
		input logic gaps);
		int idle;
		idle = gaps ? ($random(seed) & 3) : 0;
		repeat (idle) begin
			@(posedge clk);
			ts_valid <= 1'b0;
		end
		@(posedge clk);
		ts_data <= value;
		ts_sync <= sync;
		ts_valid <= 1'b1;
	endtask

	// the three filler bytes after a packet push its last byte out of the delay line.
	task automatic send_packet(input logic hdr_sync, input logic gaps);
		logic hit;
		hit = hdr_sync && (pkt[0] == `TS_SYNC_BYTE) && ({pkt[1][4:0], pkt[2]} == model_pid)
			&& model_flag && model_enable;
		if (hit) begin
			model_busy = 1'b1;
			model_known[model_cap] = 1'b1;
			for (int n = 0; n < `TS_PACKET_BYTES; n++) begin
				model_bank[model_cap][n / `TS_WORD_BYTES][8 * (n % `TS_WORD_BYTES) +: 8] = pkt[n];
			end
		end
		for (int n = 0; n < `TS_PACKET_BYTES; n++) begin
			send_byte(pkt[n], hdr_sync && (n == 0), gaps);
		end
		repeat (3) begin
			send_byte(8'h00, 1'b0, gaps);
		end
		@(posedge clk);
		ts_valid <= 1'b0;
		model_busy = 1'b0;
	endtask

	task automatic write_cfg(input ts_monitor_pkg::bus_word_t index,
		input ts_monitor_pkg::bus_word_t data);
		ts_monitor_pkg::bus_word_t expected;
		@(posedge clk);
		cfg_write <= 1'b1;
		cfg_index <= index;
		cfg_data <= data;
		@(posedge clk);
		cfg_write <= 1'b0;
		if (index == 0) begin
			model_pid = data[12:0];
			model_flag = data[`TS_CFG_ENABLE_BIT];
		end
		expected = '0;
		expected[12:0] = model_pid;
		expected[`TS_CFG_ENABLE_BIT] = model_flag;
		@(negedge clk);
		check_value("cfg_readback", cfg_readback, expected);
	endtask

	// the bank flips unless a packet is half written, and the other bank is read.
	task automatic run_pump();
		logic rd;
		int cycle;
		int count;
		if (!model_busy) begin
			model_cap = !model_cap;
		end
		rd = !model_cap;
		cycle = 0;
		count = 0;
		@(posedge clk);
		pump_request <= 1'b1;
		@(posedge clk);
		pump_request <= 1'b0;
		do begin
			@(negedge clk);
			cycle++;
			assert (cycle < 100)
			else fail_now("timeout: pump_ready did not rise after a pump request");
			if (out_word_valid) begin
				check_value("out_word_index", 32'(out_word_index), count);
				if (model_known[rd]) begin
					check_value($sformatf("out_word[%0d]", count), out_word,
						model_bank[rd][count]);
				end
				count++;
			end
		end while (!pump_ready);
		check_value("out_word_valid count", count, `TS_PACKET_WORDS);
		check_value("pump_ready rise cycle", cycle, `TS_PACKET_WORDS + 2);
	endtask

	task automatic pump_after_reset();
		@(negedge clk);
		check_value("pump_ready", 32'(pump_ready), 0);
		check_value("out_word_valid", 32'(out_word_valid), 0);
		check_value("cfg_readback", cfg_readback, 0);
		run_pump();
	endtask

	task automatic config_readback();
		// junk in the unused bits must not reach the readback.
		write_cfg(0, 32'hdead_eabc);
		write_cfg(3, 32'h0000_1234);
	endtask

	task automatic capture_matched();
		build_packet(`TS_SYNC_BYTE, 13'h0abc);
		send_packet(1'b1, 1'b1);
		run_pump();
	endtask

	task automatic drop_unmatched();
		build_packet(`TS_SYNC_BYTE, 13'h0abc);
		send_packet(1'b1, 1'b0);
		build_packet(`TS_SYNC_BYTE, 13'h0abd);
		send_packet(1'b1, 1'b0);
		write_cfg(0, 32'h0000_0abc);
		build_packet(`TS_SYNC_BYTE, 13'h0abc);
		send_packet(1'b1, 1'b0);
		write_cfg(0, 32'h0001_0abc);
		@(posedge clk);
		match_enable <= 1'b0;
		model_enable = 1'b0;
		build_packet(`TS_SYNC_BYTE, 13'h0abc);
		send_packet(1'b1, 1'b0);
		@(posedge clk);
		match_enable <= 1'b1;
		model_enable = 1'b1;
		run_pump();
	endtask

	task automatic ignore_false_sync();
		build_packet(`TS_SYNC_BYTE, 13'h0abc);
		send_packet(1'b0, 1'b1);
		build_packet(8'h48, 13'h0abc);
		send_packet(1'b1, 1'b1);
		run_pump();
	endtask

	task automatic pump_during_capture();
		build_packet(`TS_SYNC_BYTE, 13'h0abc);
		fork
			send_packet(1'b1, 1'b0);
			begin
				repeat (40) @(posedge clk);
				run_pump();
			end
		join
		run_pump();
	endtask

	initial begin
		rst_n <= 1'b0;
		ts_data <= '0;
		ts_sync <= 1'b0;
		ts_valid <= 1'b0;
		match_enable <= 1'b1;
		cfg_write <= 1'b0;
		cfg_index <= '0;
		cfg_data <= '0;
		pump_request <= 1'b0;
		model_known[0] = 1'b0;
		model_known[1] = 1'b0;
		model_cap = 1'b0;
		model_busy = 1'b0;
		model_enable = 1'b1;
		model_flag = 1'b0;
		model_pid = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		pump_after_reset();
		config_readback();
		capture_matched();
		drop_unmatched();
		ignore_false_sync();
		pump_during_capture();
		$display("All checks passed");
		$finish;
	end

endmodule
